/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module rv_core_tb -o rv_core_sim &&
./obj_dir/rv_core_sim || exit 1

/* tb/rv_core_props.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_props (
    input wire                              clk,
    input wire                              resetn,
    input wire                              trap,
    input wire                              mem_valid,
    input wire                              mem_instr,
    input wire                              mem_ready,
    input wire [rv_core_pkg::xlen-1:0]      mem_addr,
    input wire [rv_core_pkg::xlen-1:0]      mem_wdata,
    input wire [rv_core_pkg::xlen/8-1:0]    mem_wstrb
);
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata)
            && $stable(mem_wstrb) && $stable(mem_instr))
        else $error("bus request changed while waiting for mem_ready");

    a_release: assert property (@(posedge clk) disable iff (!resetn)
        mem_valid && mem_ready |=> !mem_valid)
        else $error("mem_valid stayed high after the transfer");

    a_fetch_read: assert property (@(posedge clk) disable iff (!resetn)
        mem_valid && mem_instr |-> mem_wstrb == '0)
        else $error("instruction fetch carried a write strobe");

    // Trap is sticky and the bus stays quiet once it is up
    a_trap_sticky: assert property (@(posedge clk) disable iff (!resetn)
        trap |=> trap)
        else $error("trap dropped before reset");

    a_trap_quiet: assert property (@(posedge clk) disable iff (!resetn)
        trap |-> !mem_valid)
        else $error("memory request issued after trap");

endmodule

bind rv_core rv_core_props i_props (
    .clk(clk),
    .resetn(resetn),
    .trap(trap),
    .mem_valid(mem_valid),
    .mem_instr(mem_instr),
    .mem_ready(mem_ready),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb)
);

`default_nettype wire

/* tb/rv_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;

    logic        clk = 1'b0;
    logic        resetn;
    logic        mem_ready;
    logic [31:0] mem_rdata;
    wire         trap;
    wire         mem_valid;
    wire         mem_instr;
    wire  [31:0] mem_addr;
    wire  [31:0] mem_wdata;
    wire  [3:0]  mem_wstrb;

    logic [31:0] mem [0:255];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] lcg_state = 32'h4547_1188;
    logic [31:0] rnd;
    logic        armed = 1'b0;
    int          delay = 0;
    int          exp_idx = 0;
    int          asm_pc = 0;
    int          slot_addr = 'h300;  // Result slots sit above the program
    int          prog_words = 0;

    rv_core i_dut (
        .clk, .resetn, .trap, .mem_valid, .mem_instr, .mem_ready, .mem_addr, .mem_wdata,
        .mem_wstrb, .mem_rdata
    );

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd,
                                           input logic [6:0] op);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], rv_core_pkg::f3_word, imm[4:0],
                rv_core_pkg::op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
                rv_core_pkg::op_branch};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_core_pkg::op_jal};
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic emit(input logic [31:0] word);
        mem[asm_pc / 4] = word;
        asm_pc = asm_pc + 4;
    endtask

    // Stores rs into the next result slot and records what that slot must hold
    task automatic save_reg(input int rs, input logic [31:0] value);
        emit(s_type(slot_addr, rs, 0));
        exp_addr.push_back(slot_addr);
        exp_data.push_back(value);
        slot_addr = slot_addr + 4;
    endtask

    task automatic skip_marker();
        emit(s_type('h2FC, 1, 0));  // Lies outside the result slots
    endtask

    task automatic check_op(input logic [31:0] word, input int rd, input logic [31:0] value);
        emit(word);
        save_reg(rd, value);
    endtask

    task automatic alu_imm(input logic [2:0] f3, input int rd, input int rs1, input int imm,
                           input logic [31:0] value);
        check_op(i_type(imm, rs1, f3, rd, rv_core_pkg::op_imm), rd, value);
    endtask

    task automatic alu_reg(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                           input int rs1, input int rs2, input logic [31:0] value);
        check_op(r_type(f7, rs2, rs1, f3, rd, rv_core_pkg::op_reg), rd, value);
    endtask

    task automatic shift_pair(input logic [6:0] f7, input logic [2:0] f3, input int shamt,
                              input int amt_reg, input logic [31:0] value);
        check_op(r_type(f7, shamt, 1, f3, 27, rv_core_pkg::op_imm), 27, value);
        check_op(r_type(f7, amt_reg, 1, f3, 28, rv_core_pkg::op_reg), 28, value);
    endtask

    // First branch must jump over a marker, second one falls into a checked store
    task automatic branch_pair(input logic [2:0] f3, input int t1, input int t2,
                               input int n1, input int n2);
        emit(b_type(f3, t1, t2, 8));
        skip_marker();
        emit(b_type(f3, n1, n2, 8));
        save_reg(3, 32'd7);
    endtask

    task automatic build_program();
        int          p;
        int          amt [4];
        int          amt_reg [4];
        logic [31:0] sll_exp [4];
        logic [31:0] srl_exp [4];
        logic [31:0] sra_exp [4];
        for (int i = 0; i < 256; i++)
            mem[i] = 32'hA5A5_0000 | (i * 4);  // Low bits 00 never form a legal opcode
        check_op(u_type('h87654, 1, rv_core_pkg::op_lui), 1, 32'h8765_4000);
        alu_imm(rv_core_pkg::f3_add, 1, 1, 'h321, 32'h8765_4321);
        alu_imm(rv_core_pkg::f3_add, 2, 0, -5, 32'hFFFF_FFFB);
        alu_imm(rv_core_pkg::f3_add, 3, 0, 7, 32'd7);
        alu_imm(rv_core_pkg::f3_slt, 4, 2, -4, 32'd1);
        alu_imm(rv_core_pkg::f3_sltu, 5, 2, 7, 32'd0);
        alu_imm(rv_core_pkg::f3_xor, 6, 1, 'h0F0, 32'h8765_43D1);
        alu_imm(rv_core_pkg::f3_or, 7, 1, -256, 32'hFFFF_FF21);
        alu_imm(rv_core_pkg::f3_and, 8, 1, 'h7F0, 32'h0000_0320);
        alu_reg(7'h00, rv_core_pkg::f3_add, 9, 1, 2, 32'h8765_431C);
        alu_reg(7'h20, rv_core_pkg::f3_add, 10, 3, 2, 32'h0000_000C);
        alu_reg(7'h00, rv_core_pkg::f3_slt, 11, 2, 3, 32'd1);
        alu_reg(7'h00, rv_core_pkg::f3_sltu, 12, 2, 3, 32'd0);
        alu_reg(7'h00, rv_core_pkg::f3_xor, 13, 1, 2, 32'h789A_BCDA);
        alu_reg(7'h00, rv_core_pkg::f3_or, 14, 1, 3, 32'h8765_4327);
        alu_reg(7'h00, rv_core_pkg::f3_and, 15, 1, 2, 32'h8765_4321);
        check_op(u_type('h12345, 16, rv_core_pkg::op_auipc), 16,
                 32'h1234_5000 + asm_pc);
        alu_imm(rv_core_pkg::f3_add, 17, 0, 1, 32'd1);
        alu_imm(rv_core_pkg::f3_add, 18, 0, 13, 32'd13);
        alu_imm(rv_core_pkg::f3_add, 19, 0, -1, 32'hFFFF_FFFF);  // Low five bits give 31
        amt = '{0, 1, 13, 31};
        amt_reg = '{0, 17, 18, 19};
        sll_exp = '{32'h8765_4321, 32'h0ECA_8642, 32'hA864_2000, 32'h8000_0000};
        srl_exp = '{32'h8765_4321, 32'h43B2_A190, 32'h0004_3B2A, 32'h0000_0001};
        sra_exp = '{32'h8765_4321, 32'hC3B2_A190, 32'hFFFC_3B2A, 32'hFFFF_FFFF};
        for (int k = 0; k < 4; k++) begin
            shift_pair(7'h00, rv_core_pkg::f3_sll, amt[k], amt_reg[k], sll_exp[k]);
            shift_pair(7'h00, rv_core_pkg::f3_sr, amt[k], amt_reg[k], srl_exp[k]);
            shift_pair(7'h20, rv_core_pkg::f3_sr, amt[k], amt_reg[k], sra_exp[k]);
        end
        alu_imm(rv_core_pkg::f3_add, 20, 0, 7, 32'd7);
        branch_pair(rv_core_pkg::f3_beq, 3, 20, 3, 2);
        branch_pair(rv_core_pkg::f3_bne, 3, 2, 3, 20);
        branch_pair(rv_core_pkg::f3_blt, 2, 3, 3, 2);
        branch_pair(rv_core_pkg::f3_bge, 3, 2, 2, 3);
        branch_pair(rv_core_pkg::f3_bltu, 3, 2, 2, 3);
        branch_pair(rv_core_pkg::f3_bgeu, 2, 3, 3, 2);
        p = asm_pc;
        emit(j_type(8, 21));
        skip_marker();
        save_reg(21, p + 4);
        p = asm_pc;
        emit(u_type(0, 22, rv_core_pkg::op_auipc));
        emit(i_type(13, 22, rv_core_pkg::f3_jalr, 23, rv_core_pkg::op_jalr));  // Bit 0 drops
        skip_marker();
        save_reg(23, p + 8);
        p = slot_addr;
        save_reg(1, 32'h8765_4321);
        alu_imm(rv_core_pkg::f3_add, 26, 0, p + 8, p + 8);
        emit(i_type(-8, 26, rv_core_pkg::f3_word, 24, rv_core_pkg::op_load));
        save_reg(24, 32'h8765_4321);
        save_reg(0, 32'd0);
        emit(32'h0000_0073);  // ECALL is illegal here and ends the program
        prog_words = asm_pc / 4;
    endtask

    task automatic serve_request();
        logic exp_instr;
        exp_instr = mem_wstrb == 4'h0 && mem_addr < 32'h300;  // Only the program area is fetched
        assert (mem_addr < 32'h400)
            else stop_with_failure($sformatf("access to %h lies outside the memory", mem_addr));
        assert (mem_instr == exp_instr)
            else stop_with_failure($sformatf("ERR %0t mem_instr expected %b actual %b",
                                             $time, exp_instr, mem_instr));
        mem_ready = 1'b1;
        if (mem_wstrb == 4'h0) begin
            mem_rdata = mem[mem_addr[9:2]];
        end else begin
            assert (mem_wstrb == 4'hF)
                else stop_with_failure($sformatf("ERR %0t mem_wstrb expected %h actual %h",
                                                 $time, 4'hF, mem_wstrb));
            assert (exp_idx < exp_addr.size())
                else stop_with_failure($sformatf("unexpected extra store of %h to %h",
                                                 mem_wdata, mem_addr));
            assert (mem_addr == exp_addr[exp_idx])
                else stop_with_failure($sformatf("ERR %0t mem_addr expected %h actual %h",
                                                 $time, exp_addr[exp_idx], mem_addr));
            assert (mem_wdata == exp_data[exp_idx])
                else stop_with_failure($sformatf("ERR %0t mem_wdata expected %h actual %h",
                                                 $time, exp_data[exp_idx], mem_wdata));
            mem[mem_addr[9:2]] = mem_wdata;
            exp_idx++;
        end
    endtask

    // Holds each request for 0 to 3 extra cycles
    always @(negedge clk) begin
        if (!resetn || !mem_valid || mem_ready) begin
            mem_ready = 1'b0;
            armed = 1'b0;
        end else begin
            if (!armed) begin
                rnd = next_rand();
                delay = int'(rnd[31:30]);
                armed = 1'b1;
            end
            if (delay == 0)
                serve_request();
            else
                delay = delay - 1;
        end
    end

    initial begin
        wait (prog_words > 0);
        repeat (prog_words * 200 * 3) @(posedge clk);  // 3 is the longest ready delay
        stop_with_failure("watchdog expired before the program reached its trap");
    end

    initial begin
        resetn = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        build_program();
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        wait (trap === 1'b1);
        repeat (4) @(negedge clk);  // The stopped core must stay quiet for a few cycles
        if (exp_idx == exp_addr.size()) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_with_failure($sformatf("trap raised after only %0d of %0d expected stores",
                                        exp_idx, exp_addr.size()));
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/rv_core_pkg.sv
verilog/rv_mem_port.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_control.sv
verilog/rv_core.sv
tb/rv_core_props.sv
tb/rv_core_tb.sv

/* verilog/rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
    input  wire                            clk,
    input  wire                            resetn,
    input  wire rv_core_pkg::alu_op_t      alu_op,
    input  wire  [rv_core_pkg::xlen-1:0]   op_a,
    input  wire  [rv_core_pkg::xlen-1:0]   op_b,
    output logic [rv_core_pkg::xlen-1:0]   result,
    output logic                           cond,
    input  wire                            shift_start,
    output logic                           shift_done
);
    logic                         sh_busy;
    logic [4:0]                   sh_cnt;
    logic [rv_core_pkg::xlen-1:0] sh_val;

    wire eq  = op_a == op_b;
    wire lts = $signed(op_a) < $signed(op_b);
    wire ltu = op_a < op_b;

    assign shift_done = sh_busy && sh_cnt == 5'd0;

    always_comb begin
        result = op_a + op_b;
        cond   = 1'b0;
        case (alu_op)
            rv_core_pkg::add:    result = op_a + op_b;
            rv_core_pkg::sub:    result = op_a - op_b;
            rv_core_pkg::slt:    result = {31'b0, lts};
            rv_core_pkg::sltu:   result = {31'b0, ltu};
            rv_core_pkg::xor_op: result = op_a ^ op_b;
            rv_core_pkg::or_op:  result = op_a | op_b;
            rv_core_pkg::and_op: result = op_a & op_b;
            rv_core_pkg::sll, rv_core_pkg::srl, rv_core_pkg::sra:
                result = sh_val;
            rv_core_pkg::beq:    cond = eq;
            rv_core_pkg::bne:    cond = !eq;
            rv_core_pkg::blt:    cond = lts;
            rv_core_pkg::bge:    cond = !lts;
            rv_core_pkg::bltu:   cond = ltu;
            rv_core_pkg::bgeu:   cond = !ltu;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            sh_busy <= 1'b0;
        else if (shift_start)
            sh_busy <= 1'b1;
        else if (shift_done)
            sh_busy <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (shift_start) begin
            sh_val <= op_a;
            sh_cnt <= op_b[4:0];  // Only the low five bits count in RV32I
        end else if (sh_busy && sh_cnt != 5'd0) begin
            sh_cnt <= sh_cnt - 5'd1;
            case (alu_op)
                rv_core_pkg::sll: sh_val <= sh_val << 1;
                rv_core_pkg::sra: sh_val <= $signed(sh_val) >>> 1;
                default:          sh_val <= sh_val >> 1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_control.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_control (
    input  wire                                   clk,
    input  wire                                   resetn,
    input  wire rv_core_pkg::insn_class_t         insn_class,
    input  wire rv_core_pkg::alu_op_t             alu_op,
    input  wire                                   use_imm,
    input  wire  [rv_core_pkg::reg_idx_bits-1:0]  insn_rd,
    input  wire  [rv_core_pkg::xlen-1:0]          imm,
    output logic                                  load_insn,
    input  wire  [rv_core_pkg::xlen-1:0]          rs1_data,
    input  wire  [rv_core_pkg::xlen-1:0]          rs2_data,
    output logic [rv_core_pkg::xlen-1:0]          op_a,
    output logic [rv_core_pkg::xlen-1:0]          op_b,
    input  wire  [rv_core_pkg::xlen-1:0]          result,
    input  wire                                   cond,
    output logic                                  shift_start,
    input  wire                                   shift_done,
    output logic                                  start,
    output logic                                  is_write,
    output logic                                  is_instr,
    output logic [rv_core_pkg::xlen-1:0]          addr,
    output logic [rv_core_pkg::xlen-1:0]          wdata,
    input  wire                                   done,
    input  wire  [rv_core_pkg::xlen-1:0]          rdata,
    output logic                                  we,
    output logic [rv_core_pkg::reg_idx_bits-1:0]  rd,
    output logic [rv_core_pkg::xlen-1:0]          rd_data,
    output logic                                  trap
);
    rv_core_pkg::cpu_state_t      state;
    logic [rv_core_pkg::xlen-1:0] pc;
    logic [rv_core_pkg::xlen-1:0] next_pc;

    wire [rv_core_pkg::xlen-1:0] pc_plus4  = pc + 32'd4;
    wire [rv_core_pkg::xlen-1:0] pc_target = pc + imm;

    wire is_shift = insn_class == rv_core_pkg::cls_alu &&
                    alu_op inside {rv_core_pkg::sll, rv_core_pkg::srl, rv_core_pkg::sra};
    wire is_link = insn_class == rv_core_pkg::cls_jal || insn_class == rv_core_pkg::cls_jalr;

    assign op_a = (insn_class == rv_core_pkg::cls_upper) ? pc : rs1_data;  // AUIPC adds to pc
    assign op_b = use_imm ? imm : rs2_data;

    assign is_instr = state == rv_core_pkg::st_fetch;
    assign is_write = state == rv_core_pkg::st_store;
    assign start = is_instr || is_write || state == rv_core_pkg::st_load;
    assign addr = is_instr ? pc : result;  // Data address is rs1 plus imm from the ALU
    assign wdata = rs2_data;

    assign load_insn = is_instr && done;
    assign shift_start = state == rv_core_pkg::st_decode && is_shift;
    assign trap = state == rv_core_pkg::st_trap;

    // Branches keep immediate bits in the rd field
    assign rd = (insn_class == rv_core_pkg::cls_branch) ? '0 : insn_rd;
    assign we = state == rv_core_pkg::st_exec ||
                (state == rv_core_pkg::st_shift && shift_done) ||
                (state == rv_core_pkg::st_load && done);
    assign rd_data = (state == rv_core_pkg::st_load) ? rdata : (is_link ? pc_plus4 : result);

    always_comb begin
        case (insn_class)
            rv_core_pkg::cls_jal:    next_pc = pc_target;
            rv_core_pkg::cls_jalr:   next_pc = {result[31:1], 1'b0};
            rv_core_pkg::cls_branch: next_pc = cond ? pc_target : pc_plus4;
            default:                 next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= rv_core_pkg::st_fetch;
            pc    <= rv_core_pkg::progaddr_reset;
        end else begin
            case (state)
                rv_core_pkg::st_fetch: begin
                    if (done)
                        state <= rv_core_pkg::st_decode;
                end
                rv_core_pkg::st_decode: begin
                    case (insn_class)
                        rv_core_pkg::cls_illegal: state <= rv_core_pkg::st_trap;
                        rv_core_pkg::cls_load:    state <= rv_core_pkg::st_load;
                        rv_core_pkg::cls_store:   state <= rv_core_pkg::st_store;
                        default: state <= is_shift ? rv_core_pkg::st_shift : rv_core_pkg::st_exec;
                    endcase
                end
                rv_core_pkg::st_exec: begin
                    pc    <= next_pc;
                    state <= rv_core_pkg::st_fetch;
                end
                rv_core_pkg::st_shift: begin
                    if (shift_done) begin
                        pc    <= next_pc;
                        state <= rv_core_pkg::st_fetch;
                    end
                end
                rv_core_pkg::st_load, rv_core_pkg::st_store: begin
                    if (done) begin
                        pc    <= next_pc;
                        state <= rv_core_pkg::st_fetch;
                    end
                end
                default: ;  // Trap holds until reset
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  wire                                clk,
    input  wire                                resetn,
    output wire                                trap,
    output wire                                mem_valid,
    output wire                                mem_instr,
    input  wire                                mem_ready,
    output wire [rv_core_pkg::xlen-1:0]        mem_addr,
    output wire [rv_core_pkg::xlen-1:0]        mem_wdata,
    output wire [rv_core_pkg::xlen/8-1:0]      mem_wstrb,
    input  wire [rv_core_pkg::xlen-1:0]        mem_rdata
);
    wire                                   start;
    wire                                   is_write;
    wire                                   is_instr;
    wire                                   done;
    wire [rv_core_pkg::xlen-1:0]           addr;
    wire [rv_core_pkg::xlen-1:0]           wdata;
    wire [rv_core_pkg::xlen-1:0]           rdata;
    wire                                   load_insn;
    rv_core_pkg::insn_class_t              insn_class;
    rv_core_pkg::alu_op_t                  alu_op;
    wire                                   use_imm;
    wire [rv_core_pkg::reg_idx_bits-1:0]   dec_rd;
    wire [rv_core_pkg::reg_idx_bits-1:0]   rs1;
    wire [rv_core_pkg::reg_idx_bits-1:0]   rs2;
    wire [rv_core_pkg::reg_idx_bits-1:0]   wr_rd;
    wire [rv_core_pkg::xlen-1:0]           imm;
    wire [rv_core_pkg::xlen-1:0]           rs1_data;
    wire [rv_core_pkg::xlen-1:0]           rs2_data;
    wire [rv_core_pkg::xlen-1:0]           op_a;
    wire [rv_core_pkg::xlen-1:0]           op_b;
    wire [rv_core_pkg::xlen-1:0]           result;
    wire                                   cond;
    wire                                   shift_start;
    wire                                   shift_done;
    wire                                   we;
    wire [rv_core_pkg::xlen-1:0]           rd_data;

    rv_mem_port i_mem_port (
        .clk, .resetn, .start, .is_write, .is_instr, .addr, .wdata, .done, .rdata,
        .mem_valid, .mem_instr, .mem_ready, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata
    );

    rv_decoder i_decoder (
        .clk, .resetn, .load_insn, .insn(rdata), .insn_class, .alu_op, .use_imm,
        .rd(dec_rd), .rs1, .rs2, .imm
    );

    rv_alu i_alu (
        .clk, .resetn, .alu_op, .op_a, .op_b, .result, .cond, .shift_start, .shift_done
    );

    rv_regfile i_regfile (
        .clk, .rs1, .rs2, .rs1_data, .rs2_data, .we, .rd(wr_rd), .rd_data
    );

    rv_control i_control (
        .clk, .resetn, .insn_class, .alu_op, .use_imm, .insn_rd(dec_rd), .imm, .load_insn,
        .rs1_data, .rs2_data, .op_a, .op_b, .result, .cond, .shift_start, .shift_done,
        .start, .is_write, .is_instr, .addr, .wdata, .done, .rdata,
        .we, .rd(wr_rd), .rd_data, .trap
    );

endmodule

`default_nettype wire

/* verilog/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;
    localparam int reg_idx_bits = 5;
    localparam logic [xlen-1:0] progaddr_reset = 32'h0000_0000;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // SRL and SRA, told apart by funct7
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_jalr = 3'b000;

    typedef enum logic [3:0] {
        add, sub, slt, sltu, xor_op, or_op, and_op, sll,
        srl, sra, beq, bne, blt, bge, bltu, bgeu
    } alu_op_t;

    typedef enum logic [2:0] {
        cls_upper, cls_jal, cls_jalr, cls_branch, cls_load, cls_store, cls_alu, cls_illegal
    } insn_class_t;

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_exec, st_shift, st_load, st_store, st_trap
    } cpu_state_t;

endpackage

`default_nettype wire

/* verilog/rv_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_decoder (
    input  wire                                   clk,
    input  wire                                   resetn,
    input  wire                                   load_insn,
    input  wire  [rv_core_pkg::xlen-1:0]          insn,
    output rv_core_pkg::insn_class_t              insn_class,
    output rv_core_pkg::alu_op_t                  alu_op,
    output logic                                  use_imm,
    output logic [rv_core_pkg::reg_idx_bits-1:0]  rd,
    output logic [rv_core_pkg::reg_idx_bits-1:0]  rs1,
    output logic [rv_core_pkg::reg_idx_bits-1:0]  rs2,
    output logic [rv_core_pkg::xlen-1:0]          imm
);
    wire [6:0] opcode = insn[6:0];
    wire [2:0] funct3 = insn[14:12];
    wire [6:0] funct7 = insn[31:25];

    wire [31:0] imm_i = {{20{insn[31]}}, insn[31:20]};
    wire [31:0] imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    wire [31:0] imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    wire [31:0] imm_u = {insn[31:12], 12'b0};
    wire [31:0] imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

    wire is_lui = opcode == rv_core_pkg::op_lui;
    wire is_imm = opcode == rv_core_pkg::op_imm;

    // Funct7 of 0100000 is legal only for SRA(I) and SUB
    wire f7_ok = funct7 == 7'b0000000 || (funct7 == 7'b0100000 &&
                 (funct3 == rv_core_pkg::f3_sr || (!is_imm && funct3 == rv_core_pkg::f3_add)));
    wire f7_free = is_imm && funct3 != rv_core_pkg::f3_sll && funct3 != rv_core_pkg::f3_sr;

    rv_core_pkg::insn_class_t     cls_d;
    rv_core_pkg::alu_op_t         op_d;
    logic                         use_imm_d;
    logic [rv_core_pkg::xlen-1:0] imm_d;

    always_comb begin
        cls_d     = rv_core_pkg::cls_illegal;
        op_d      = rv_core_pkg::add;
        use_imm_d = 1'b1;
        imm_d     = imm_i;
        case (opcode)
            rv_core_pkg::op_lui: begin
                cls_d = rv_core_pkg::cls_alu;  // Executes as x0 plus the U immediate
                imm_d = imm_u;
            end
            rv_core_pkg::op_auipc: begin
                cls_d = rv_core_pkg::cls_upper;
                imm_d = imm_u;
            end
            rv_core_pkg::op_jal: begin
                cls_d = rv_core_pkg::cls_jal;
                imm_d = imm_j;
            end
            rv_core_pkg::op_jalr: begin
                if (funct3 == rv_core_pkg::f3_jalr)
                    cls_d = rv_core_pkg::cls_jalr;
            end
            rv_core_pkg::op_branch: begin
                cls_d     = rv_core_pkg::cls_branch;
                use_imm_d = 1'b0;
                imm_d     = imm_b;
                case (funct3)
                    rv_core_pkg::f3_beq:  op_d = rv_core_pkg::beq;
                    rv_core_pkg::f3_bne:  op_d = rv_core_pkg::bne;
                    rv_core_pkg::f3_blt:  op_d = rv_core_pkg::blt;
                    rv_core_pkg::f3_bge:  op_d = rv_core_pkg::bge;
                    rv_core_pkg::f3_bltu: op_d = rv_core_pkg::bltu;
                    rv_core_pkg::f3_bgeu: op_d = rv_core_pkg::bgeu;
                    default:              cls_d = rv_core_pkg::cls_illegal;
                endcase
            end
            rv_core_pkg::op_load: begin
                if (funct3 == rv_core_pkg::f3_word)
                    cls_d = rv_core_pkg::cls_load;
            end
            rv_core_pkg::op_store: begin
                imm_d = imm_s;
                if (funct3 == rv_core_pkg::f3_word)
                    cls_d = rv_core_pkg::cls_store;
            end
            rv_core_pkg::op_imm, rv_core_pkg::op_reg: begin
                use_imm_d = is_imm;
                if (f7_free || f7_ok)
                    cls_d = rv_core_pkg::cls_alu;
                case (funct3)
                    rv_core_pkg::f3_add:  op_d = (!is_imm && funct7[5]) ? rv_core_pkg::sub
                                                                        : rv_core_pkg::add;
                    rv_core_pkg::f3_sll:  op_d = rv_core_pkg::sll;
                    rv_core_pkg::f3_slt:  op_d = rv_core_pkg::slt;
                    rv_core_pkg::f3_sltu: op_d = rv_core_pkg::sltu;
                    rv_core_pkg::f3_xor:  op_d = rv_core_pkg::xor_op;
                    rv_core_pkg::f3_sr:   op_d = funct7[5] ? rv_core_pkg::sra : rv_core_pkg::srl;
                    rv_core_pkg::f3_or:   op_d = rv_core_pkg::or_op;
                    rv_core_pkg::f3_and:  op_d = rv_core_pkg::and_op;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            insn_class <= rv_core_pkg::cls_illegal;
        else if (load_insn)
            insn_class <= cls_d;
    end

    always_ff @(posedge clk) begin
        if (load_insn) begin
            alu_op  <= op_d;
            use_imm <= use_imm_d;
            imm     <= imm_d;
            rd      <= insn[11:7];
            rs1     <= is_lui ? '0 : insn[19:15];
            rs2     <= insn[24:20];
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_mem_port.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_mem_port (
    input  wire                                clk,
    input  wire                                resetn,
    input  wire                                start,
    input  wire                                is_write,
    input  wire                                is_instr,
    input  wire  [rv_core_pkg::xlen-1:0]       addr,
    input  wire  [rv_core_pkg::xlen-1:0]       wdata,
    output logic                               done,
    output logic [rv_core_pkg::xlen-1:0]       rdata,
    output logic                               mem_valid,
    output logic                               mem_instr,
    input  wire                                mem_ready,
    output logic [rv_core_pkg::xlen-1:0]       mem_addr,
    output logic [rv_core_pkg::xlen-1:0]       mem_wdata,
    output logic [rv_core_pkg::xlen/8-1:0]     mem_wstrb,
    input  wire  [rv_core_pkg::xlen-1:0]       mem_rdata
);
    // The port is busy exactly while mem_valid is high
    wire accept = !mem_valid && start && !done;  // Start is still high in the done cycle
    wire xfer = mem_valid && mem_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
            mem_instr <= 1'b0;
            mem_wstrb <= '0;
            done      <= 1'b0;
        end else begin
            done <= xfer;
            if (accept) begin
                mem_valid <= 1'b1;
                mem_instr <= is_instr;
                mem_wstrb <= {(rv_core_pkg::xlen/8){is_write}};
            end else if (xfer) begin
                mem_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_addr  <= addr;
            mem_wdata <= wdata;
        end
        if (xfer)
            rdata <= mem_rdata;
    end

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
    input  wire         clk,
    input  wire  [4:0]  rs1,
    input  wire  [4:0]  rs2,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  wire         we,
    input  wire  [4:0]  rd,
    input  wire  [31:0] rd_data
);
    logic [31:0] regs [0:31];  // Entry zero is never written

    assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0)
            regs[rd] <= rd_data;
    end

endmodule

`default_nettype wire
